// File: source/soc_pkg.sv
`default_nettype none

package soc_pkg;

    ////////////////////////////////////////
    // Bus and memory widths
    ////////////////////////////////////////
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic  [3:0] bytesel_t;

    typedef logic  [8:0] rom_addr_t;
    typedef logic [10:0] tram_addr_t;
    typedef logic [15:0] half_t;

    // Register slot from address bits 7..2
    typedef logic  [5:0] reg_index_t;

    // Serial bridge and video register widths
    typedef logic  [8:0] esp_data_t;
    typedef logic  [8:0] scroll_x_t;
    typedef logic  [7:0] line_t;

    // Video control, MSB first
    // text page, 80 columns, border remap, text priority,
    // sprites enable, gfx mode (2 bits), text enable
    typedef logic  [7:0] vctrl_t;

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_TRAM,
        REGION_REGS,
        REGION_BOOTROM
    } region_e;

    ////////////////////////////////////////
    // Region map
    ////////////////////////////////////////
    // Text RAM decodes on bits 31..12
    localparam addr_t TRAM_BASE    = 32'hFF00_0000;
    // Registers decode on bits 31..14
    localparam addr_t REGS_BASE    = 32'hFF50_0000;
    // Boot ROM decodes on bits 31..11
    localparam addr_t BOOTROM_BASE = 32'hFFFF_F800;

    localparam int BOOTROM_WORDS = 512;
    localparam int TRAM_WORDS    = 2048;

    ////////////////////////////////////////
    // Register slots
    ////////////////////////////////////////
    localparam reg_index_t REG_ESPCTRL  = 6'd0;
    localparam reg_index_t REG_ESPDATA  = 6'd1;
    localparam reg_index_t REG_VCTRL    = 6'd2;
    localparam reg_index_t REG_VSCRX    = 6'd3;
    localparam reg_index_t REG_VSCRY    = 6'd4;
    localparam reg_index_t REG_VLINE    = 6'd5;
    localparam reg_index_t REG_VIRQLINE = 6'd6;

    // ESPCTRL bit positions, bit 2 reads zero
    localparam int ESPCTRL_RX_READY_BIT = 0;
    localparam int ESPCTRL_TX_FULL_BIT  = 1;
    localparam int ESPCTRL_FRAMING_BIT  = 3;
    localparam int ESPCTRL_OVERFLOW_BIT = 4;

endpackage

`default_nettype wire

// File: source/bus_interconnect.sv
`default_nettype none
`timescale 1ns/1ps

module bus_interconnect import soc_pkg::*; (
    input  wire         clk,
    input  wire         reset,

    // CPU side
    input  wire addr_t  bus_addr,
    input  wire         bus_wren,
    input  wire         bus_strobe,
    output logic        bus_wait,
    output word_t       bus_rddata,

    // Region selects
    output logic        tram_sel,
    output logic        regs_sel,
    output logic        rom_sel,

    // Read data from the slaves
    input  wire word_t  rom_rddata,
    input  wire half_t  tram_rddata,
    input  wire word_t  regs_rddata
);

    region_e region;
    region_e q_region;
    addr_t   q_addr;
    logic    q_valid;
    logic    mem_read;
    logic    repeat_read;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////
    always_comb begin
        region = REGION_NONE;
        if (bus_strobe) begin
            if (bus_addr[31:12] == TRAM_BASE[31:12])
                region = REGION_TRAM;
            else if (bus_addr[31:14] == REGS_BASE[31:14])
                region = REGION_REGS;
            else if (bus_addr[31:11] == BOOTROM_BASE[31:11])
                region = REGION_BOOTROM;
        end
    end

    assign tram_sel = (region == REGION_TRAM);
    assign regs_sel = (region == REGION_REGS);
    assign rom_sel  = (region == REGION_BOOTROM);

    ////////////////////////////////////////
    // Read wait states
    ////////////////////////////////////////
    // Last cycle's access, valid only when it was a read
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            q_valid <= 1'b0;
        else
            q_valid <= bus_strobe && !bus_wren;
    end

    always_ff @(posedge clk) begin
        q_addr   <= bus_addr;
        q_region <= region;
    end

    // Synchronous memories need one cycle to present data
    assign mem_read    = !bus_wren &&
                         (region == REGION_TRAM || region == REGION_BOOTROM);
    assign repeat_read = q_valid && (q_region == region) && (q_addr == bus_addr);
    assign bus_wait    = mem_read && !repeat_read;

    ////////////////////////////////////////
    // Read data mux
    ////////////////////////////////////////
    always_comb begin
        case (region)
            // Halfword shows on both bus halves
            REGION_TRAM:    bus_rddata = {tram_rddata, tram_rddata};
            REGION_REGS:    bus_rddata = regs_rddata;
            REGION_BOOTROM: bus_rddata = rom_rddata;
            default:        bus_rddata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/sys_regs.sv
`default_nettype none
`timescale 1ns/1ps

module sys_regs import soc_pkg::*; (
    input  wire             clk,
    input  wire             reset,

    // CPU side
    input  wire             regs_sel,
    input  wire addr_t      bus_addr,
    input  wire word_t      bus_wrdata,
    input  wire             bus_wren,
    output word_t           regs_rddata,

    // Serial bridge FIFOs
    output esp_data_t       esp_tx_data,
    output logic            esp_tx_wr,
    input  wire             esp_tx_full,
    input  wire esp_data_t  esp_rx_data,
    output logic            esp_rx_rd,
    input  wire             esp_rx_empty,
    input  wire             esp_rx_overflow,
    input  wire             esp_rx_framing_error,

    // Video
    output vctrl_t          vctrl,
    output scroll_x_t       vscrx,
    output line_t           vscry,
    output line_t           virqline,
    input  wire line_t      vline
);

    reg_index_t slot;
    logic       reg_wr;
    logic       espdata_sel;
    logic       rx_overflow_flag;
    logic       rx_framing_flag;
    logic       clr_overflow;
    logic       clr_framing;

    assign slot        = bus_addr[7:2];
    assign reg_wr      = regs_sel && bus_wren;
    assign espdata_sel = regs_sel && (slot == REG_ESPDATA);

    ////////////////////////////////////////
    // Serial FIFO strobes
    ////////////////////////////////////////
    // Registers never wait, so every strobed cycle completes
    assign esp_tx_data = bus_wrdata[8:0];
    assign esp_tx_wr   = espdata_sel && bus_wren;
    assign esp_rx_rd   = espdata_sel && !bus_wren;

    // Write one to clear
    assign clr_overflow = reg_wr && (slot == REG_ESPCTRL) &&
                          bus_wrdata[ESPCTRL_OVERFLOW_BIT];
    assign clr_framing  = reg_wr && (slot == REG_ESPCTRL) &&
                          bus_wrdata[ESPCTRL_FRAMING_BIT];

    ////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_overflow_flag <= 1'b0;
            rx_framing_flag  <= 1'b0;
            vctrl            <= '0;
            vscrx            <= '0;
            vscry            <= '0;
            virqline         <= '0;
        end else begin
            // New error pulse beats a clear in the same cycle
            if (esp_rx_overflow)
                rx_overflow_flag <= 1'b1;
            else if (clr_overflow)
                rx_overflow_flag <= 1'b0;

            if (esp_rx_framing_error)
                rx_framing_flag <= 1'b1;
            else if (clr_framing)
                rx_framing_flag <= 1'b0;

            if (reg_wr) begin
                case (slot)
                    REG_VCTRL:    vctrl    <= bus_wrdata[7:0];
                    REG_VSCRX:    vscrx    <= bus_wrdata[8:0];
                    REG_VSCRY:    vscry    <= bus_wrdata[7:0];
                    REG_VIRQLINE: virqline <= bus_wrdata[7:0];
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // Read values
    ////////////////////////////////////////
    always_comb begin
        regs_rddata = '0;
        case (slot)
            REG_ESPCTRL: begin
                regs_rddata[ESPCTRL_RX_READY_BIT] = !esp_rx_empty;
                regs_rddata[ESPCTRL_TX_FULL_BIT]  = esp_tx_full;
                regs_rddata[ESPCTRL_FRAMING_BIT]  = rx_framing_flag;
                regs_rddata[ESPCTRL_OVERFLOW_BIT] = rx_overflow_flag;
            end
            REG_ESPDATA:  regs_rddata = word_t'(esp_rx_data);
            REG_VCTRL:    regs_rddata = word_t'(vctrl);
            REG_VSCRX:    regs_rddata = word_t'(vscrx);
            REG_VSCRY:    regs_rddata = word_t'(vscry);
            REG_VLINE:    regs_rddata = word_t'(vline);
            REG_VIRQLINE: regs_rddata = word_t'(virqline);
            default:      regs_rddata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/boot_rom.sv
`default_nettype none
`timescale 1ns/1ps

module boot_rom import soc_pkg::*; (
    input  wire            clk,
    input  wire rom_addr_t addr,
    output word_t          rddata
);

    word_t mem [BOOTROM_WORDS];

    // Clear first so words past the end of the file read zero
    initial begin
        for (int i = 0; i < BOOTROM_WORDS; i++)
            mem[i] = '0;
        $readmemh("boot_rom.hex", mem);
    end

    // Registered output, data follows the address by one cycle
    always_ff @(posedge clk) begin
        rddata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: source/text_ram.sv
`default_nettype none
`timescale 1ns/1ps

module text_ram import soc_pkg::*; (
    input  wire             clk,
    input  wire tram_addr_t addr,
    input  wire half_t      wrdata,
    input  wire       [1:0] bytesel,
    input  wire             wren,
    output half_t           rddata
);

    half_t mem [TRAM_WORDS];

    ////////////////////////////////////////
    // Byte lane writes
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wren) begin
            if (bytesel[0])
                mem[addr][7:0] <= wrdata[7:0];
            if (bytesel[1])
                mem[addr][15:8] <= wrdata[15:8];
        end
    end

    ////////////////////////////////////////
    // Registered read
    ////////////////////////////////////////
    // Old data on a read during write to the same halfword
    always_ff @(posedge clk) begin
        rddata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: source/soc_bus_top.sv
`default_nettype none
`timescale 1ns/1ps

module soc_bus_top import soc_pkg::*; (
    input  wire             clk,
    input  wire             reset,

    // CPU bus
    input  wire addr_t      bus_addr,
    input  wire word_t      bus_wrdata,
    input  wire bytesel_t   bus_bytesel,
    input  wire             bus_wren,
    input  wire             bus_strobe,
    output logic            bus_wait,
    output word_t           bus_rddata,

    // Serial bridge FIFOs
    output esp_data_t       esp_tx_data,
    output logic            esp_tx_wr,
    input  wire             esp_tx_full,
    input  wire esp_data_t  esp_rx_data,
    output logic            esp_rx_rd,
    input  wire             esp_rx_empty,
    input  wire             esp_rx_overflow,
    input  wire             esp_rx_framing_error,

    // Video
    output vctrl_t          vctrl,
    output scroll_x_t       vscrx,
    output line_t           vscry,
    output line_t           virqline,
    input  wire line_t      vline
);

    logic  tram_sel;
    logic  regs_sel;
    logic  rom_sel;
    logic  tram_wren;
    word_t rom_rddata;
    half_t tram_rddata;
    word_t regs_rddata;

    assign tram_wren = tram_sel && bus_wren;

    ////////////////////////////////////////
    // Interconnect
    ////////////////////////////////////////
    bus_interconnect interconnect0 (
        .clk         (clk),
        .reset       (reset),
        .bus_addr    (bus_addr),
        .bus_wren    (bus_wren),
        .bus_strobe  (bus_strobe),
        .bus_wait    (bus_wait),
        .bus_rddata  (bus_rddata),
        .tram_sel    (tram_sel),
        .regs_sel    (regs_sel),
        .rom_sel     (rom_sel),
        .rom_rddata  (rom_rddata),
        .tram_rddata (tram_rddata),
        .regs_rddata (regs_rddata)
    );

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////
    sys_regs regs0 (
        .clk                  (clk),
        .reset                (reset),
        .regs_sel             (regs_sel),
        .bus_addr             (bus_addr),
        .bus_wrdata           (bus_wrdata),
        .bus_wren             (bus_wren),
        .regs_rddata          (regs_rddata),
        .esp_tx_data          (esp_tx_data),
        .esp_tx_wr            (esp_tx_wr),
        .esp_tx_full          (esp_tx_full),
        .esp_rx_data          (esp_rx_data),
        .esp_rx_rd            (esp_rx_rd),
        .esp_rx_empty         (esp_rx_empty),
        .esp_rx_overflow      (esp_rx_overflow),
        .esp_rx_framing_error (esp_rx_framing_error),
        .vctrl                (vctrl),
        .vscrx                (vscrx),
        .vscry                (vscry),
        .virqline             (virqline),
        .vline                (vline)
    );

    ////////////////////////////////////////
    // Memories
    ////////////////////////////////////////
    boot_rom rom0 (
        .clk    (clk),
        .addr   (bus_addr[10:2]),
        .rddata (rom_rddata)
    );

    // Both halfword lane pairs land on the one 16-bit RAM
    text_ram tram0 (
        .clk     (clk),
        .addr    (bus_addr[11:1]),
        .wrdata  (bus_wrdata[15:0]),
        .bytesel (bus_bytesel[3:2] | bus_bytesel[1:0]),
        .wren    (tram_wren),
        .rddata  (tram_rddata)
    );

endmodule

`default_nettype wire

// File: bench/soc_bus_asserts.sv
`default_nettype none
`timescale 1ns/1ps

module soc_bus_asserts (
    input wire clk,
    input wire reset,
    input wire bus_strobe,
    input wire bus_wren,
    input wire bus_wait,
    input wire esp_tx_wr,
    input wire esp_rx_rd,
    input wire tram_sel,
    input wire regs_sel,
    input wire rom_sel
);

    ////////////////////////////////////////
    // Bus protocol
    ////////////////////////////////////////
    // Writes always complete in the cycle they are presented
    write_no_wait: assert property (@(posedge clk) disable iff (reset)
        (bus_strobe && bus_wren) |-> !bus_wait)
        else $error("bus_wait high during a write");

    ////////////////////////////////////////
    // Serial strobes and selects
    ////////////////////////////////////////
    fifo_strobes_apart: assert property (@(posedge clk) disable iff (reset)
        !(esp_tx_wr && esp_rx_rd))
        else $error("esp_tx_wr and esp_rx_rd high together");

    one_select: assert property (@(posedge clk) disable iff (reset)
        $onehot0({tram_sel, regs_sel, rom_sel}))
        else $error("more than one region select high");

endmodule

bind soc_bus_top soc_bus_asserts asserts0 (
    .clk        (clk),
    .reset      (reset),
    .bus_strobe (bus_strobe),
    .bus_wren   (bus_wren),
    .bus_wait   (bus_wait),
    .esp_tx_wr  (esp_tx_wr),
    .esp_rx_rd  (esp_rx_rd),
    .tram_sel   (tram_sel),
    .regs_sel   (regs_sel),
    .rom_sel    (rom_sel)
);

`default_nettype wire

// File: bench/tb_soc_bus.sv
`default_nettype none
`timescale 1ns/1ps

module tb_soc_bus import soc_pkg::*; ();

    localparam int MAX_CYCLES = 4000;

    logic      clk;
    logic      reset;
    addr_t     bus_addr;
    word_t     bus_wrdata;
    bytesel_t  bus_bytesel;
    logic      bus_wren;
    logic      bus_strobe;
    logic      bus_wait;
    word_t     bus_rddata;
    esp_data_t esp_tx_data;
    logic      esp_tx_wr;
    logic      esp_tx_full;
    esp_data_t esp_rx_data = '0;
    logic      esp_rx_rd;
    logic      esp_rx_empty = 1'b1;
    logic      esp_rx_overflow;
    logic      esp_rx_framing_error;
    vctrl_t    vctrl;
    scroll_x_t vscrx;
    line_t     vscry;
    line_t     virqline;
    line_t     vline = '0;
    logic [2:0] line_div = '0;

    // Reference model state
    word_t     rom_image [BOOTROM_WORDS];
    half_t     tram_shadow [TRAM_WORDS];
    addr_t     tram_used [$];
    esp_data_t rx_queue [$];
    vctrl_t    m_vctrl;
    scroll_x_t m_vscrx;
    line_t     m_vscry;
    line_t     m_virqline;
    logic      m_overflow;
    logic      m_framing;
    logic      prev_valid;
    addr_t     prev_addr;
    int        tx_count = 0;
    int        rx_pops = 0;
    esp_data_t tx_last = '0;
    int        cycles = 0;
    int        seed;

    soc_bus_top dut0 (
        .clk                  (clk),
        .reset                (reset),
        .bus_addr             (bus_addr),
        .bus_wrdata           (bus_wrdata),
        .bus_bytesel          (bus_bytesel),
        .bus_wren             (bus_wren),
        .bus_strobe           (bus_strobe),
        .bus_wait             (bus_wait),
        .bus_rddata           (bus_rddata),
        .esp_tx_data          (esp_tx_data),
        .esp_tx_wr            (esp_tx_wr),
        .esp_tx_full          (esp_tx_full),
        .esp_rx_data          (esp_rx_data),
        .esp_rx_rd            (esp_rx_rd),
        .esp_rx_empty         (esp_rx_empty),
        .esp_rx_overflow      (esp_rx_overflow),
        .esp_rx_framing_error (esp_rx_framing_error),
        .vctrl                (vctrl),
        .vscrx                (vscrx),
        .vscry                (vscry),
        .virqline             (virqline),
        .vline                (vline)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: timeout, the run did not end within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////
    // Peripheral models
    ////////////////////////////////////////
    // Receive FIFO with its head shown on esp_rx_data
    always @(posedge clk) begin
        if (esp_rx_rd && rx_queue.size() != 0) begin
            void'(rx_queue.pop_front());
            rx_pops = rx_pops + 1;
        end
        esp_rx_data  <= (rx_queue.size() != 0) ? rx_queue[0] : '0;
        esp_rx_empty <= (rx_queue.size() == 0);
    end

    always @(posedge clk) begin
        if (!reset && esp_tx_wr) begin
            tx_count = tx_count + 1;
            tx_last  = esp_tx_data;
        end
    end

    // Raster counter advancing one line every 8 clocks
    always @(posedge clk) begin
        line_div <= line_div + 3'd1;
        if (line_div == 3'd7)
            vline <= vline + 8'd1;
    end

    ////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////
    function automatic logic in_tram(input addr_t a);
        return a >= TRAM_BASE && a < TRAM_BASE + 32'h0000_1000;
    endfunction

    function automatic logic in_regs(input addr_t a);
        return a >= REGS_BASE && a < REGS_BASE + 32'h0000_4000;
    endfunction

    function automatic addr_t reg_addr(input reg_index_t slot);
        return REGS_BASE + addr_t'({slot, 2'b00});
    endfunction

    function automatic word_t expected_read(input addr_t a);
        word_t r;
        r = '0;
        if (a >= BOOTROM_BASE) begin
            r = rom_image[a[10:2]];
        end else if (in_tram(a)) begin
            r = {tram_shadow[a[11:1]], tram_shadow[a[11:1]]};
        end else if (in_regs(a)) begin
            case (a[7:2])
                REG_ESPCTRL: begin
                    r[ESPCTRL_RX_READY_BIT] = (rx_queue.size() != 0);
                    r[ESPCTRL_TX_FULL_BIT]  = esp_tx_full;
                    r[ESPCTRL_FRAMING_BIT]  = m_framing;
                    r[ESPCTRL_OVERFLOW_BIT] = m_overflow;
                end
                REG_ESPDATA:  r = (rx_queue.size() != 0) ? word_t'(rx_queue[0]) : '0;
                REG_VCTRL:    r = word_t'(m_vctrl);
                REG_VSCRX:    r = word_t'(m_vscrx);
                REG_VSCRY:    r = word_t'(m_vscry);
                REG_VLINE:    r = word_t'(vline);
                REG_VIRQLINE: r = word_t'(m_virqline);
                default:      r = '0;
            endcase
        end
        return r;
    endfunction

    // Memory reads wait once unless the last cycle read the same address
    function automatic int expected_latency(input addr_t a);
        if ((a >= BOOTROM_BASE || in_tram(a)) && !(prev_valid && prev_addr == a))
            return 2;
        return 1;
    endfunction

    task automatic model_write(input addr_t a, input word_t d, input bytesel_t bs);
        if (in_tram(a)) begin
            if (bs[0] || bs[2])
                tram_shadow[a[11:1]][7:0] = d[7:0];
            if (bs[1] || bs[3])
                tram_shadow[a[11:1]][15:8] = d[15:8];
        end else if (in_regs(a)) begin
            case (a[7:2])
                REG_ESPCTRL: begin
                    if (d[ESPCTRL_OVERFLOW_BIT])
                        m_overflow = 1'b0;
                    if (d[ESPCTRL_FRAMING_BIT])
                        m_framing = 1'b0;
                end
                REG_VCTRL:    m_vctrl    = d[7:0];
                REG_VSCRX:    m_vscrx    = d[8:0];
                REG_VSCRY:    m_vscry    = d[7:0];
                REG_VIRQLINE: m_virqline = d[7:0];
                default: ;
            endcase
        end
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Every completing read is compared against the model
    always @(negedge clk) begin
        if (!reset && bus_strobe && !bus_wren && !bus_wait)
            check_value("bus_rddata", bus_rddata, expected_read(bus_addr));
    end

    ////////////////////////////////////////
    // CPU bus driver
    ////////////////////////////////////////
    // Holds the access until the edge where bus_wait is low
    task automatic wait_complete(input int exp_cycles);
        int   n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            n++;
            done = !bus_wait;
            @(posedge clk);
        end
        check_value("bus latency", word_t'(n), word_t'(exp_cycles));
    endtask

    task automatic bus_write(input addr_t a, input word_t d, input bytesel_t bs);
        bus_addr    <= a;
        bus_wrdata  <= d;
        bus_bytesel <= bs;
        bus_wren    <= 1'b1;
        bus_strobe  <= 1'b1;
        wait_complete(1);
        model_write(a, d, bs);
        prev_valid = 1'b0;
    endtask

    task automatic bus_read(input addr_t a);
        int lat;
        lat = expected_latency(a);
        bus_addr   <= a;
        bus_wren   <= 1'b0;
        bus_strobe <= 1'b1;
        wait_complete(lat);
        prev_valid = 1'b1;
        prev_addr  = a;
    endtask

    task automatic bus_idle();
        bus_strobe <= 1'b0;
        bus_wren   <= 1'b0;
        @(posedge clk);
        prev_valid = 1'b0;
    endtask

    task automatic pulse_errors(input logic ovf, input logic framing);
        esp_rx_overflow      <= ovf;
        esp_rx_framing_error <= framing;
        bus_idle();
        esp_rx_overflow      <= 1'b0;
        esp_rx_framing_error <= 1'b0;
        if (ovf)
            m_overflow = 1'b1;
        if (framing)
            m_framing = 1'b1;
    endtask

    ////////////////////////////////////////
    // Test sequences
    ////////////////////////////////////////
    task automatic rom_tests();
        logic [31:0] r;
        addr_t       a;
        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            // Half inside the file, half anywhere in the ROM
            if (r[31])
                a = BOOTROM_BASE + addr_t'({r[3:0], 2'b00});
            else
                a = BOOTROM_BASE + addr_t'({r[8:0], 2'b00});
            bus_read(a);
            bus_read(a);
            bus_idle();
        end
    endtask

    task automatic tram_tests();
        logic [31:0] r;
        word_t       d;
        addr_t       a;
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            a = TRAM_BASE + addr_t'({r[10:0], 1'b0});
            d = $random(seed);
            bus_write(a, d, 4'b0011);
            bus_read(a);
            r = $random(seed);
            d = $random(seed);
            bus_write(a, d, r[3:0]);
            bus_read(a);
            tram_used.push_back(a);
        end
        bus_idle();
    endtask

    task automatic check_video_ports();
        check_value("vctrl", word_t'(vctrl), word_t'(m_vctrl));
        check_value("vscrx", word_t'(vscrx), word_t'(m_vscrx));
        check_value("vscry", word_t'(vscry), word_t'(m_vscry));
        check_value("virqline", word_t'(virqline), word_t'(m_virqline));
    endtask

    task automatic video_tests();
        word_t d;
        for (int slot = 2; slot <= 6; slot++) begin
            d = $random(seed);
            bus_write(reg_addr(reg_index_t'(slot)), d, 4'hF);
            bus_read(reg_addr(reg_index_t'(slot)));
        end
        bus_idle();
        check_video_ports();
        // Vertical scroll has its own slot apart from the interrupt line
        d = $random(seed);
        bus_write(reg_addr(REG_VSCRY), d, 4'hF);
        bus_idle();
        check_video_ports();
        for (int i = 0; i < 4; i++) begin
            repeat (5) bus_idle();
            bus_read(reg_addr(REG_VLINE));
        end
        bus_read(reg_addr(6'd7));
        bus_read(reg_addr(6'd63));
        bus_idle();
    endtask

    task automatic serial_tests();
        logic [31:0] r;
        int          pops0;
        int          tx0;
        esp_tx_full <= 1'b0;
        for (int i = 0; i < 3; i++) begin
            r = $random(seed);
            rx_queue.push_back(r[8:0]);
        end
        repeat (2) bus_idle();
        bus_read(reg_addr(REG_ESPCTRL));
        pops0 = rx_pops;
        tx0   = tx_count;
        bus_read(reg_addr(REG_ESPDATA));
        bus_idle();
        check_value("rx pop count", word_t'(rx_pops), word_t'(pops0 + 1));
        bus_read(reg_addr(REG_ESPDATA));
        bus_read(reg_addr(REG_ESPDATA));
        bus_idle();
        check_value("rx pop count", word_t'(rx_pops), word_t'(pops0 + 3));
        check_value("tx write count", word_t'(tx_count), word_t'(tx0));
        bus_read(reg_addr(REG_ESPCTRL));
        // A full FIFO does not block the write strobe
        esp_tx_full <= 1'b1;
        bus_idle();
        bus_read(reg_addr(REG_ESPCTRL));
        r = $random(seed);
        bus_write(reg_addr(REG_ESPDATA), r, 4'hF);
        bus_idle();
        check_value("tx write count", word_t'(tx_count), word_t'(tx0 + 1));
        check_value("esp_tx_data", word_t'(tx_last), word_t'(r[8:0]));
        check_value("rx pop count", word_t'(rx_pops), word_t'(pops0 + 3));
        esp_tx_full <= 1'b0;
        bus_idle();
    endtask

    task automatic sticky_tests();
        pulse_errors(1'b1, 1'b0);
        bus_read(reg_addr(REG_ESPCTRL));
        pulse_errors(1'b1, 1'b1);
        bus_read(reg_addr(REG_ESPCTRL));
        bus_write(reg_addr(REG_ESPCTRL), 32'h1 << ESPCTRL_OVERFLOW_BIT, 4'hF);
        bus_read(reg_addr(REG_ESPCTRL));
        pulse_errors(1'b0, 1'b1);
        bus_read(reg_addr(REG_ESPCTRL));
        bus_write(reg_addr(REG_ESPCTRL), 32'h1 << ESPCTRL_FRAMING_BIT, 4'hF);
        bus_read(reg_addr(REG_ESPCTRL));
        bus_idle();
    endtask

    task automatic unmapped_tests();
        addr_t list [5];
        word_t d;
        int    pops0;
        int    tx0;
        list = '{32'h0000_0004, 32'hFF00_1002, 32'hFF50_4004, 32'hFFFF_F7FC, 32'h8000_0008};
        // Halfword that FF00_1002 would hit if bit 12 were not decoded
        d = $random(seed);
        bus_write(TRAM_BASE + 32'h0000_0002, d, 4'hF);
        tram_used.push_back(TRAM_BASE + 32'h0000_0002);
        pops0 = rx_pops;
        tx0   = tx_count;
        foreach (list[i]) begin
            d = $random(seed);
            bus_write(list[i], d, 4'hF);
            bus_read(list[i]);
        end
        bus_idle();
        check_value("tx write count", word_t'(tx_count), word_t'(tx0));
        check_value("rx pop count", word_t'(rx_pops), word_t'(pops0));
        check_video_ports();
        foreach (tram_used[i])
            bus_read(tram_used[i]);
        for (int slot = 0; slot <= 6; slot++)
            bus_read(reg_addr(reg_index_t'(slot)));
        bus_idle();
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        clk                  = 1'b0;
        reset                = 1'b1;
        bus_addr             = '0;
        bus_wrdata           = '0;
        bus_bytesel          = '0;
        bus_wren             = 1'b0;
        bus_strobe           = 1'b0;
        esp_tx_full          = 1'b0;
        esp_rx_overflow      = 1'b0;
        esp_rx_framing_error = 1'b0;
        seed                 = 32'h801a_bf3c;
        m_vctrl              = '0;
        m_vscrx              = '0;
        m_vscry              = '0;
        m_virqline           = '0;
        m_overflow           = 1'b0;
        m_framing            = 1'b0;
        prev_valid           = 1'b0;
        prev_addr            = '0;
        for (int i = 0; i < BOOTROM_WORDS; i++)
            rom_image[i] = '0;
        $readmemh("boot_rom.hex", rom_image);

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        rom_tests();
        tram_tests();
        video_tests();
        serial_tests();
        sticky_tests();
        unmapped_tests();
        repeat (2) bus_idle();

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: boot_rom.hex
// One 32-bit hex word per line, boot ROM words 0 to 15
3c1cff50
279c0000
8f820000
30420001
1040fffd
00000000
8f830004
a0030000
24840001
1485fff8
00000000
3c08ffff
3508f800
01000008
00000000
deadc0de

// File: project.f
source/soc_pkg.sv
source/bus_interconnect.sv
source/sys_regs.sv
source/boot_rom.sv
source/text_ram.sv
source/soc_bus_top.sv
bench/soc_bus_asserts.sv
bench/tb_soc_bus.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_bus
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The ROM image is read at run time from the project root
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG) || { echo "Simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
